// ==== build.f ====
+incdir+.
cache_addr_pkg.sv
cache_req_pkg.sv
cache_lookup.sv
miss_queue.sv
refill_ctrl.sv
nb_cache_top.sv
tb_clock_gen.sv
nb_cache_tb.sv

// ==== cache_addr_pkg.sv ====
`include "cache_config.svh"

package cache_addr_pkg;

	localparam int TAG_W = `CACHE_ADDR_W - `CACHE_INDEX_W;	// bits above the index

	// full word address
	typedef logic [`CACHE_ADDR_W-1:0] addr_t;

	// line index, low address bits
	typedef logic [`CACHE_INDEX_W-1:0] index_t;

	// stored tag
	typedef logic [TAG_W-1:0] tag_t;

	// one data word
	typedef logic [`CACHE_DATA_W-1:0] data_t;

endpackage

// ==== cache_config.svh ====
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// word address width
`define CACHE_ADDR_W 32

// data word, also the line width
`define CACHE_DATA_W 32

// 16 direct mapped lines
`define CACHE_INDEX_W 4

// core load/store id
`define CACHE_ID_W 3

// outstanding misses
`define MISS_DEPTH 4

`endif

// ==== cache_lookup.sv ====
`timescale 1ns/1ns
`include "cache_config.svh"

module cache_lookup import cache_addr_pkg::*, cache_req_pkg::*; (
	input  logic     clk,
	input  logic     reset,

	input  logic     valid_i,
	input  logic     we_i,
	input  addr_t    addr_i,
	input  data_t    wdata_i,
	input  core_id_t id_i,

	output logic     hit_ready_o,
	output data_t    hit_data_o,
	output core_id_t hit_id_o,
	output logic     stall_o,

	output logic     push_o,
	output addr_t    miss_addr_o,
	output logic     miss_we_o,
	output data_t    miss_wdata_o,
	output core_id_t miss_id_o,
	output index_t   probe_index_o,
	input  logic     full_i,
	input  logic     match_i,

	input  index_t   fill_index_i,
	input  logic     fill_we_i,
	input  tag_t     fill_tag_i,
	input  data_t    fill_data_i,
	input  logic     fill_dirty_i,

	output tag_t     victim_tag_o,
	output data_t    victim_data_o,
	output logic     victim_dirty_o,
	output logic     victim_valid_o
);

	localparam int LINES = 1 << `CACHE_INDEX_W;

	logic [LINES-1:0] valid_q;
	logic [LINES-1:0] dirty_q;
	tag_t             tag_mem [LINES];
	data_t            data_mem [LINES];

	index_t req_index;
	tag_t   req_tag;
	logic   hit;
	logic   accept;

	assign req_index = addr_i[`CACHE_INDEX_W-1:0];
	assign req_tag   = addr_i[`CACHE_ADDR_W-1:`CACHE_INDEX_W];
	assign hit       = valid_q[req_index] && (tag_mem[req_index] == req_tag);

	// an install owns the array and the reply path for one cycle
	assign stall_o = full_i | match_i | fill_we_i;
	assign accept  = valid_i & ~stall_o;

	assign probe_index_o = req_index;	// queue searches on the incoming index
	assign push_o        = accept & ~hit;
	assign miss_addr_o   = addr_i;
	assign miss_we_o     = we_i;
	assign miss_wdata_o  = wdata_i;
	assign miss_id_o     = id_i;

	// second read port, addressed by the refill controller
	assign victim_tag_o   = tag_mem[fill_index_i];
	assign victim_data_o  = data_mem[fill_index_i];
	assign victim_dirty_o = dirty_q[fill_index_i];
	assign victim_valid_o = valid_q[fill_index_i];

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (fill_we_i) begin
			valid_q[fill_index_i] <= 1'b1;
			dirty_q[fill_index_i] <= fill_dirty_i;	// set for a merged store
		end else if (accept && hit && we_i) begin
			dirty_q[req_index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fill_we_i) begin
			tag_mem[fill_index_i]  <= fill_tag_i;
			data_mem[fill_index_i] <= fill_data_i;
		end else if (accept && hit && we_i) begin
			data_mem[req_index] <= wdata_i;	// store hit
		end
	end

	// read hits answer one cycle after acceptance
	always_ff @(posedge clk or negedge reset) begin
		if (!reset)
			hit_ready_o <= 1'b0;
		else
			hit_ready_o <= accept & hit & ~we_i;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			hit_data_o <= data_mem[req_index];
			hit_id_o   <= id_i;
		end
	end

endmodule

// ==== cache_req_pkg.sv ====
`include "cache_config.svh"

package cache_req_pkg;

	localparam int MISS_PTR_W = $clog2(`MISS_DEPTH);

	// id the core attaches to a load or store
	typedef logic [`CACHE_ID_W-1:0] core_id_t;

	// slot pointer into the miss queue
	typedef logic [MISS_PTR_W-1:0] miss_ptr_t;

	// fill level, one bit wider so full is representable
	typedef logic [MISS_PTR_W:0] miss_count_t;

endpackage

// ==== miss_queue.sv ====
`timescale 1ns/1ns
`include "cache_config.svh"

module miss_queue import cache_addr_pkg::*, cache_req_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     push_i,
	input  addr_t    addr_i,
	input  logic     we_i,
	input  data_t    wdata_i,
	input  core_id_t id_i,
	input  logic     pop_i,
	input  index_t   probe_index_i,
	output addr_t    head_addr_o,
	output logic     head_we_o,
	output data_t    head_wdata_o,
	output core_id_t head_id_o,
	output logic     empty_o,
	output logic     full_o,
	output logic     match_o
);

	addr_t                  addr_q [`MISS_DEPTH];
	logic                   we_q [`MISS_DEPTH];
	data_t                  wdata_q [`MISS_DEPTH];
	core_id_t               id_q [`MISS_DEPTH];
	logic [`MISS_DEPTH-1:0] valid_q;
	miss_ptr_t              wr_ptr_q;
	miss_ptr_t              rd_ptr_q;
	miss_count_t            count_q;

	function automatic miss_ptr_t ptr_next(miss_ptr_t ptr);
		if (ptr == miss_ptr_t'(`MISS_DEPTH - 1))
			return '0;
		return miss_ptr_t'(ptr + 1'b1);
	endfunction

	assign head_addr_o  = addr_q[rd_ptr_q];
	assign head_we_o    = we_q[rd_ptr_q];
	assign head_wdata_o = wdata_q[rd_ptr_q];
	assign head_id_o    = id_q[rd_ptr_q];
	assign empty_o      = (count_q == '0);
	assign full_o       = (count_q == miss_count_t'(`MISS_DEPTH));

	// any live entry on the probed line
	always_comb begin
		match_o = 1'b0;
		for (int i = 0; i < `MISS_DEPTH; i++) begin
			if (valid_q[i] && (addr_q[i][`CACHE_INDEX_W-1:0] == probe_index_i))
				match_o = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			valid_q  <= '0;
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push_i) begin
				valid_q[wr_ptr_q] <= 1'b1;
				wr_ptr_q          <= ptr_next(wr_ptr_q);
			end
			if (pop_i) begin
				valid_q[rd_ptr_q] <= 1'b0;	// slot free at this edge
				rd_ptr_q          <= ptr_next(rd_ptr_q);
			end
			case ({push_i, pop_i})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push_i) begin
			addr_q[wr_ptr_q]  <= addr_i;
			we_q[wr_ptr_q]    <= we_i;
			wdata_q[wr_ptr_q] <= wdata_i;
			id_q[wr_ptr_q]    <= id_i;
		end
	end

endmodule

// ==== nb_cache_tb.sv ====
`timescale 1ns/1ns
`include "cache_config.svh"

module nb_cache_tb import cache_addr_pkg::*, cache_req_pkg::*; ();

	localparam int N_RAND = 120;
	localparam int N_SWEEP = 32;
	localparam int MAX_DELAY = 8;
	localparam int LIMIT = (N_RAND + N_SWEEP) * (2 * MAX_DELAY + 10);

	logic clk, reset;
	logic valid_i = 1'b0, we_i = 1'b0;
	addr_t addr_i = '0;
	data_t wdata_i = '0;
	core_id_t id_i = '0;
	logic ready_o, stall_o, mem_req_o, mem_we_o;
	data_t data_o, mem_wdata_o;
	core_id_t id_o;
	addr_t mem_addr_o;
	logic mem_stall_i = 1'b0, mem_valid_i = 1'b0;
	data_t mem_rdata_i = '0;

	logic [31:0] lfsr = 32'hc717;
	data_t shadow [addr_t];	// latest store per address
	data_t mem_a [addr_t];
	logic [7:0] pending = '0;	// reads waiting for a reply, by id
	data_t exp_data [8];
	logic res_valid [16];
	tag_t res_tag [16];
	index_t miss_idx [$];	// model of the miss queue
	addr_t rd_addr [$];
	int rd_due [$];
	int cycle = 0, last_due = 0, check_errs = 0, other_errs = 0;
	logic hit_expect = 1'b0, pop_next = 1'b0, accepted_q = 1'b0;
	core_id_t hit_expect_id;

	tb_clock_gen u_clock (.clk_o(clk), .reset_o(reset));

	nb_cache_top DUT (
		.clk(clk), .reset(reset), .valid_i(valid_i), .we_i(we_i), .addr_i(addr_i),
		.wdata_i(wdata_i), .id_i(id_i), .ready_o(ready_o), .data_o(data_o), .id_o(id_o),
		.stall_o(stall_o), .mem_req_o(mem_req_o), .mem_we_o(mem_we_o),
		.mem_addr_o(mem_addr_o), .mem_wdata_o(mem_wdata_o), .mem_stall_i(mem_stall_i),
		.mem_valid_i(mem_valid_i), .mem_rdata_i(mem_rdata_i)
	);

	function automatic data_t init_word(addr_t a);
		return a ^ 32'h5a5a5a5a;
	endfunction

	function data_t shadow_val(addr_t a);
		return shadow.exists(a) ? shadow[a] : init_word(a);
	endfunction

	function data_t mem_val(addr_t a);
		return mem_a.exists(a) ? mem_a[a] : init_word(a);
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};	// taps 32 22 2 1
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic report_value(input string name, input data_t exp, input data_t act);
		check_errs++;
		$display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, name, exp, act);
	endtask

	task automatic drive_memory();
		logic [31:0] r;
		rand_bits(2, r);
		mem_stall_i = (r == 0);
		if (rd_due.size() > 0 && rd_due[0] <= cycle) begin
			mem_valid_i = 1'b1;
			mem_rdata_i = mem_val(rd_addr[0]);
			void'(rd_addr.pop_front());
			void'(rd_due.pop_front());
		end else begin
			mem_valid_i = 1'b0;
		end
	endtask

	always @(posedge clk) begin
		index_t idx;
		tag_t tg;
		logic busy, hitp;
		logic [31:0] r;
		if (!reset) begin
			assert (!ready_o && !stall_o && !mem_req_o && !mem_we_o) else begin
				other_errs++;
				$display("%0t ns: outputs not idle during reset", $time);
			end
		end else begin
			cycle++;
			if (hit_expect)
				assert (ready_o && id_o == hit_expect_id) else begin
					other_errs++;
					$display("%0t ns: read hit id %0d got no reply one cycle later", $time,
						hit_expect_id);
				end
			hit_expect = 1'b0;
			if (ready_o) begin
				assert (pending[id_o]) else begin
					other_errs++;
					$display("%0t ns: reply for id %0d with no read outstanding", $time, id_o);
				end
				assert (data_o == exp_data[id_o]) else report_value("data_o", exp_data[id_o], data_o);
				pending[id_o] = 1'b0;
			end
			busy = 1'b0;
			foreach (miss_idx[i])
				if (miss_idx[i] == addr_i[`CACHE_INDEX_W-1:0])
					busy = 1'b1;
			if (valid_i && (busy || miss_idx.size() == `MISS_DEPTH))
				assert (stall_o) else begin
					other_errs++;
					$display("%0t ns: request not stalled behind pending misses", $time);
				end
			if (pop_next) begin
				void'(miss_idx.pop_front());
				pop_next = 1'b0;
			end
			if (mem_valid_i)
				pop_next = 1'b1;	// install is the next cycle
			if (mem_req_o && !mem_stall_i) begin
				if (mem_we_o) begin
					assert (mem_wdata_o == shadow_val(mem_addr_o)) else
						report_value("mem_wdata_o", shadow_val(mem_addr_o), mem_wdata_o);
					mem_a[mem_addr_o] = mem_wdata_o;
				end else begin
					idx = mem_addr_o[`CACHE_INDEX_W-1:0];
					tg = mem_addr_o[`CACHE_ADDR_W-1:`CACHE_INDEX_W];
					assert (!(res_valid[idx] && res_tag[idx] == tg)) else begin
						other_errs++;
						$display("%0t ns: memory read of resident address %h", $time, mem_addr_o);
					end
					res_valid[idx] = 1'b1;
					res_tag[idx] = tg;
					rand_bits(3, r);
					last_due = (cycle + 1 + int'(r) > last_due) ? cycle + 1 + int'(r) : last_due + 1;
					rd_addr.push_back(mem_addr_o);
					rd_due.push_back(last_due);
				end
			end
			accepted_q = valid_i && !stall_o;
			if (accepted_q) begin
				idx = addr_i[`CACHE_INDEX_W-1:0];
				hitp = res_valid[idx] && res_tag[idx] == addr_i[`CACHE_ADDR_W-1:`CACHE_INDEX_W];
				if (we_i) begin
					shadow[addr_i] = wdata_i;
				end else begin
					pending[id_i] = 1'b1;
					exp_data[id_i] = shadow_val(addr_i);
					hit_expect = hitp;
					hit_expect_id = id_i;
				end
				if (!hitp)
					miss_idx.push_back(idx);
			end
		end
	end

	initial begin
		int timeout_cnt;
		timeout_cnt = 0;
		forever begin
			@(posedge clk);
			timeout_cnt++;
			if (timeout_cnt > LIMIT) begin
				$display("timeout after %0d cycles with reads still outstanding", timeout_cnt);
				$display("errors: %0d value, %0d other", check_errs, other_errs + 1);
				$display("sim failed");
				$finish;
			end
		end
	end

	initial begin
		int issued;
		int free_id;
		logic [31:0] r, tg, ix, rw;
		foreach (res_valid[i])
			res_valid[i] = 1'b0;
		issued = 0;
		@(posedge reset);
		while (issued < N_RAND + N_SWEEP) begin
			@(negedge clk);
			drive_memory();
			if (!(valid_i && !accepted_q)) begin
				valid_i = 1'b0;
				free_id = -1;
				for (int i = 7; i >= 0; i--)
					if (!pending[i])
						free_id = i;
				rand_bits(2, r);
				if (issued < N_RAND) begin
					rand_bits(1, rw);
					we_i = rw[0];
					rand_bits(2, tg);
					rand_bits(3, ix);
					addr_i = addr_t'(tg * 16 + ix);	// few tags over eight lines
					rand_bits(16, wdata_i);
				end else begin
					we_i = 1'b0;	// read back sweep, tag major
					addr_i = addr_t'(issued - N_RAND);
					addr_i = addr_t'(addr_i[4:3] * 16 + addr_i[2:0]);
					r = 1;
				end
				if (r != 0 && (we_i || free_id >= 0)) begin
					valid_i = 1'b1;
					id_i = we_i ? core_id_t'(0) : core_id_t'(free_id);
					issued++;
				end
			end
		end
		@(negedge clk);
		while (!accepted_q) begin
			drive_memory();
			@(negedge clk);
		end
		valid_i = 1'b0;
		while (pending != 0 || miss_idx.size() != 0 || rd_due.size() != 0) begin
			drive_memory();
			@(negedge clk);
		end
		repeat (4) @(negedge clk);
		$display("errors: %0d value, %0d other", check_errs, other_errs);
		if (check_errs == 0 && other_errs == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// ==== nb_cache_top.sv ====
`timescale 1ns/1ns

module nb_cache_top import cache_addr_pkg::*, cache_req_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     valid_i,
	input  logic     we_i,
	input  addr_t    addr_i,
	input  data_t    wdata_i,
	input  core_id_t id_i,
	output logic     ready_o,
	output data_t    data_o,
	output core_id_t id_o,
	output logic     stall_o,
	output logic     mem_req_o,
	output logic     mem_we_o,
	output addr_t    mem_addr_o,
	output data_t    mem_wdata_o,
	input  logic     mem_stall_i,
	input  logic     mem_valid_i,
	input  data_t    mem_rdata_i
);

	logic     hit_ready;
	data_t    hit_data;
	core_id_t hit_id;
	logic     miss_ready;
	data_t    miss_data;
	core_id_t miss_id;

	logic     push;
	addr_t    miss_addr;
	logic     miss_we;
	data_t    miss_wdata;
	core_id_t miss_cid;
	index_t   probe_index;
	logic     full;
	logic     match;

	addr_t    head_addr;
	logic     head_we;
	data_t    head_wdata;
	core_id_t head_id;
	logic     empty;
	logic     pop;

	index_t   fill_index;
	logic     fill_we;
	tag_t     fill_tag;
	data_t    fill_data;
	logic     fill_dirty;
	tag_t     victim_tag;
	data_t    victim_data;
	logic     victim_dirty;
	logic     victim_valid;

	// the two reply sources are never active together
	assign ready_o = miss_ready | hit_ready;
	assign data_o  = miss_ready ? miss_data : hit_data;
	assign id_o    = miss_ready ? miss_id : hit_id;

	cache_lookup u_lookup (
		.clk(clk), .reset(reset),
		.valid_i(valid_i), .we_i(we_i), .addr_i(addr_i), .wdata_i(wdata_i), .id_i(id_i),
		.hit_ready_o(hit_ready), .hit_data_o(hit_data), .hit_id_o(hit_id), .stall_o(stall_o),
		.push_o(push), .miss_addr_o(miss_addr), .miss_we_o(miss_we),
		.miss_wdata_o(miss_wdata), .miss_id_o(miss_cid), .probe_index_o(probe_index),
		.full_i(full), .match_i(match),
		.fill_index_i(fill_index), .fill_we_i(fill_we), .fill_tag_i(fill_tag),
		.fill_data_i(fill_data), .fill_dirty_i(fill_dirty),
		.victim_tag_o(victim_tag), .victim_data_o(victim_data),
		.victim_dirty_o(victim_dirty), .victim_valid_o(victim_valid)
	);

	miss_queue u_queue (
		.clk(clk), .reset(reset),
		.push_i(push), .addr_i(miss_addr), .we_i(miss_we), .wdata_i(miss_wdata), .id_i(miss_cid),
		.pop_i(pop), .probe_index_i(probe_index),
		.head_addr_o(head_addr), .head_we_o(head_we), .head_wdata_o(head_wdata),
		.head_id_o(head_id), .empty_o(empty), .full_o(full), .match_o(match)
	);

	refill_ctrl u_refill (
		.clk(clk), .reset(reset),
		.head_addr_i(head_addr), .head_we_i(head_we), .head_wdata_i(head_wdata),
		.head_id_i(head_id), .empty_i(empty), .pop_o(pop),
		.fill_index_o(fill_index), .fill_we_o(fill_we), .fill_tag_o(fill_tag),
		.fill_data_o(fill_data), .fill_dirty_o(fill_dirty),
		.victim_tag_i(victim_tag), .victim_data_i(victim_data),
		.victim_dirty_i(victim_dirty), .victim_valid_i(victim_valid),
		.mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
		.mem_wdata_o(mem_wdata_o), .mem_stall_i(mem_stall_i),
		.mem_valid_i(mem_valid_i), .mem_rdata_i(mem_rdata_i),
		.miss_ready_o(miss_ready), .miss_data_o(miss_data), .miss_id_o(miss_id)
	);

endmodule

// ==== refill_ctrl.sv ====
`timescale 1ns/1ns
`include "cache_config.svh"

module refill_ctrl import cache_addr_pkg::*, cache_req_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  addr_t    head_addr_i,
	input  logic     head_we_i,
	input  data_t    head_wdata_i,
	input  core_id_t head_id_i,
	input  logic     empty_i,
	output logic     pop_o,
	output index_t   fill_index_o,
	output logic     fill_we_o,
	output tag_t     fill_tag_o,
	output data_t    fill_data_o,
	output logic     fill_dirty_o,
	input  tag_t     victim_tag_i,
	input  data_t    victim_data_i,
	input  logic     victim_dirty_i,
	input  logic     victim_valid_i,
	output logic     mem_req_o,
	output logic     mem_we_o,
	output addr_t    mem_addr_o,
	output data_t    mem_wdata_o,
	input  logic     mem_stall_i,
	input  logic     mem_valid_i,
	input  data_t    mem_rdata_i,
	output logic     miss_ready_o,
	output data_t    miss_data_o,
	output core_id_t miss_id_o
);

	typedef enum logic [2:0] {
		IDLE,
		EXAMINE,
		WRITE_BACK,
		READ_REQ,
		WAIT_DATA,
		INSTALL
	} state_t;

	state_t state_q;
	state_t state_d;
	tag_t   wb_tag_q;
	data_t  wb_data_q;
	data_t  rdata_q;

	// head entry stays put until the pop
	assign fill_index_o = head_addr_i[`CACHE_INDEX_W-1:0];
	assign fill_tag_o   = head_addr_i[`CACHE_ADDR_W-1:`CACHE_INDEX_W];
	assign fill_we_o    = (state_q == INSTALL);
	assign pop_o        = fill_we_o;
	assign fill_dirty_o = head_we_i;
	assign fill_data_o  = head_we_i ? head_wdata_i : rdata_q;	// one-word line, store replaces it

	assign mem_req_o   = (state_q == WRITE_BACK) || (state_q == READ_REQ);
	assign mem_we_o    = (state_q == WRITE_BACK);
	assign mem_addr_o  = mem_we_o ? {wb_tag_q, fill_index_o} : head_addr_i;
	assign mem_wdata_o = wb_data_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (!empty_i)
					state_d = EXAMINE;
			end
			EXAMINE: begin
				if (victim_valid_i && victim_dirty_i)
					state_d = WRITE_BACK;
				else
					state_d = READ_REQ;
			end
			WRITE_BACK: begin
				if (!mem_stall_i)
					state_d = READ_REQ;
			end
			READ_REQ: begin
				if (!mem_stall_i)
					state_d = WAIT_DATA;
			end
			WAIT_DATA: begin
				if (mem_valid_i)
					state_d = INSTALL;
			end
			default: state_d = IDLE;	// install takes one cycle
		endcase
	end

	// reply lands the cycle after the install, when no hit reply can be pending
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state_q      <= IDLE;
			miss_ready_o <= 1'b0;
		end else begin
			state_q      <= state_d;
			miss_ready_o <= fill_we_o & ~head_we_i;
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == EXAMINE) begin
			wb_tag_q  <= victim_tag_i;
			wb_data_q <= victim_data_i;
		end
		if ((state_q == WAIT_DATA) && mem_valid_i)
			rdata_q <= mem_rdata_i;
		if (fill_we_o) begin
			miss_data_o <= rdata_q;
			miss_id_o   <= head_id_i;
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cache testbench, fail status on any reported failure
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module nb_cache_tb \
	-o nb_cache_sim > build.log 2>&1 || { echo "build error, see build.log"; exit 1; }
./obj_dir/nb_cache_sim > sim.log 2>&1
cat sim.log
grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log || exit 1

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
	output logic clk_o,
	output logic reset_o
);

	initial begin
		clk_o = 1'b0;
		forever #20 clk_o = ~clk_o;	// 40 ns period
	end

	initial begin
		reset_o = 1'b0;
		repeat (4) @(posedge clk_o);
		@(negedge clk_o);
		reset_o = 1'b1;
	end

endmodule
